//--- bench/wb_dcache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module wb_dcache_assertions (
    input logic                              clk_i,
    input logic                              rst_ni,
    input logic                              lsu_req_i,
    input logic                              lsu_ack_o,
    input logic                              mem_req_o,
    input logic                              mem_we_o,
    input logic                              mem_ack_i,
    input logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    input logic [dmem_pkg::LINE_WIDTH-1:0]   mem_wdata_o
);

    // Set by a write-back request, cleared once the refill read is issued
    logic wb_pending_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wb_pending_q <= 1'b0;
        end else if (mem_req_o && mem_we_o) begin
            wb_pending_q <= 1'b1;
        end else if (mem_req_o && !mem_we_o) begin
            wb_pending_q <= 1'b0;
        end
    end

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_ack_o |-> (lsu_req_i || $past(lsu_req_i)))
        else $error("lsu_ack_o high without a request");

    req_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_ack_i) |=> mem_req_o)
        else $error("mem_req_o dropped before mem_ack_i");

    mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_ack_i) |=>
            ($stable(mem_addr_o) && $stable(mem_we_o) && $stable(mem_wdata_o)))
        else $error("Memory request fields changed while mem_req_o was high");

    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_ni |=> (!lsu_ack_o && !mem_req_o))
        else $error("lsu_ack_o or mem_req_o high during reset");

    refill_before_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_pending_q |-> !lsu_ack_o)
        else $error("lsu_ack_o rose after a write-back with no refill read");

endmodule

bind wb_dcache_top wb_dcache_assertions u_assertions (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lsu_req_i   (lsu_req_i),
    .lsu_ack_o   (lsu_ack_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_ack_i   (mem_ack_i),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o)
);

`default_nettype wire

//--- bench/wb_dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wb_dcache_tb;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RANDOM_OPS     = 200;

    logic                                clk_i;
    logic                                rst_ni;
    logic                                lsu_req_i;
    logic                                lsu_we_i;
    logic [dcache_pkg::ADDR_WIDTH-1:0]   lsu_addr_i;
    logic [dcache_pkg::DATA_WIDTH-1:0]   lsu_wdata_i;
    logic [dcache_pkg::DATA_WIDTH/8-1:0] lsu_be_i;
    logic                                lsu_ack_o;
    logic [dcache_pkg::DATA_WIDTH-1:0]   lsu_rdata_o;
    logic                                mem_req_o;
    logic                                mem_we_o;
    logic [dcache_pkg::ADDR_WIDTH-1:0]   mem_addr_o;
    logic [dmem_pkg::LINE_WIDTH-1:0]     mem_wdata_o;
    logic                                mem_ack_i;
    logic [dmem_pkg::LINE_WIDTH-1:0]     mem_rdata_i;

    // Memory lines keyed by line address, shadow words keyed by word address
    logic [dmem_pkg::LINE_WIDTH-1:0] mem_lines [logic [27:0]];
    logic [31:0]                     shadow [logic [29:0]];
    logic                            log_we [$];
    logic [31:0]                     log_addr [$];
    logic [dmem_pkg::LINE_WIDTH-1:0] log_wdata [$];
    integer                          seed = 32'h144f;
    integer                          lat_seed = 32'h144f ^ 32'h0000_5555;
    int                              lat_left;

    wb_dcache_top dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lsu_req_i   (lsu_req_i),
        .lsu_we_i    (lsu_we_i),
        .lsu_addr_i  (lsu_addr_i),
        .lsu_wdata_i (lsu_wdata_i),
        .lsu_be_i    (lsu_be_i),
        .lsu_ack_o   (lsu_ack_o),
        .lsu_rdata_o (lsu_rdata_o),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    // Memory contents before any write, mixing every address bit
    function automatic logic [31:0] init_word(input logic [31:0] byte_addr);
        return {byte_addr[15:0], ~byte_addr[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [127:0] line_contents(input logic [27:0] line_addr);
        logic [127:0] line;
        int           k;
        if (mem_lines.exists(line_addr)) begin
            return mem_lines[line_addr];
        end
        for (k = 0; k < dmem_pkg::WORDS_PER_LINE; k++) begin
            line[k*32 +: 32] = init_word({line_addr, 2'(k), 2'b00});
        end
        return line;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) begin
            return shadow[addr[31:2]];
        end
        return init_word({addr[31:2], 2'b00});
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] word;
        int          b;
        word = old_word;
        for (b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return word;
    endfunction

    task automatic stop_on_failure();
        $display("Simulation FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Check failed at %0t ns: %s", $time, what);
            stop_on_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAIL at %0t ns: %s expected %h, actual %h", $time, name, exp, got);
            stop_on_failure();
        end
    endtask

    task automatic clear_mem_log();
        log_we.delete();
        log_addr.delete();
        log_wdata.delete();
    endtask

    // Four-phase LSU access, entered and left 2 ns after a rising edge
    task automatic lsu_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] be,
                              output logic [31:0] rdata, output int edges);
        int waited;
        lsu_we_i    = we;
        lsu_addr_i  = addr;
        lsu_wdata_i = wdata;
        lsu_be_i    = be;
        lsu_req_i   = 1'b1;
        edges       = 0;
        while (!lsu_ack_o) begin
            @(posedge clk_i);
            #2;
            edges++;
            if (edges > TIMEOUT_CYCLES) begin
                $display("Timeout: no lsu_ack_o for the access to address %h", addr);
                stop_on_failure();
            end
        end
        rdata     = lsu_rdata_o;
        lsu_req_i = 1'b0;
        waited    = 0;
        while (lsu_ack_o) begin
            @(posedge clk_i);
            #2;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("Timeout: lsu_ack_o stayed high after the request dropped");
                stop_on_failure();
            end
        end
    endtask

    task automatic read_and_check(input logic [31:0] addr, output int edges);
        logic [31:0] rdata;
        lsu_access(1'b0, addr, '0, 4'hf, rdata, edges);
        check_word("lsu_rdata_o", shadow_word(addr), rdata);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be);
        logic [31:0] rdata;
        int          edges;
        lsu_access(1'b1, addr, wdata, be, rdata, edges);
        shadow[addr[31:2]] = merge_bytes(shadow_word(addr), wdata, be);
    endtask

    // Line memory, answers each request after 0 to 5 extra cycles
    initial begin : memory_model
        logic [27:0] line_addr;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        lat_left    = 0;
        forever begin
            @(posedge clk_i);
            #2;
            line_addr = mem_addr_o[31:4];
            if (mem_ack_i) begin
                if (!mem_req_o) begin
                    mem_ack_i = 1'b0;
                end
            end else if (mem_req_o) begin
                if (lat_left > 0) begin
                    lat_left--;
                end else begin
                    log_we.push_back(mem_we_o);
                    log_addr.push_back(mem_addr_o);
                    log_wdata.push_back(mem_wdata_o);
                    if (mem_we_o) begin
                        mem_lines[line_addr] = mem_wdata_o;
                    end else begin
                        mem_rdata_i = line_contents(line_addr);
                    end
                    mem_ack_i = 1'b1;
                    lat_left  = int'($unsigned($random(lat_seed)) % 6);
                end
            end
        end
    end

    initial begin : stimulus
        dcache_pkg::dcache_addr_u ra;
        logic [31:0]              a1;
        logic [31:0]              a2;
        logic [31:0]              victim;
        logic [31:0]              merged;
        logic [31:0]              rnd;
        logic [31:0]              rdata;
        logic [127:0]             line;
        int                       edges;
        int                       n;
        int                       k;
        rst_ni      = 1'b0;
        lsu_req_i   = 1'b0;
        lsu_we_i    = 1'b0;
        lsu_addr_i  = '0;
        lsu_wdata_i = '0;
        lsu_be_i    = '0;
        repeat (16) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        check_true(!lsu_ack_o && !mem_req_o, "lsu_ack_o or mem_req_o high after reset");

        // Cold read refills the line
        a1 = 32'h0000_1234;
        clear_mem_log();
        read_and_check(a1, edges);
        check_true(log_we.size() == 1 && !log_we[0], "first read did not issue one memory read");

        clear_mem_log();
        read_and_check(a1, edges);
        check_true(edges == 2, "read hit did not acknowledge two edges after the request");
        check_true(log_we.size() == 0, "read hit went out to memory");

        // Initial word 4808_691e with bytes 0 and 2 taken from dead_beef
        merged = 32'h48ad_69ef;
        write_word(a1, 32'hdead_beef, 4'b0101);
        lsu_access(1'b0, a1, '0, 4'hf, rdata, edges);
        check_word("lsu_rdata_o", merged, rdata);

        // Same index, other tag: dirty victim goes out before the refill
        a2     = a1 + 32'h0000_0400;
        victim = a1 & 32'hffff_fff0;
        clear_mem_log();
        read_and_check(a2, edges);
        check_true(log_we.size() == 2, "dirty miss did not issue a write-back and a refill");
        check_true(log_we[0] && !log_we[1], "write-back did not come before the refill");
        check_word("mem_addr_o", victim, log_addr[0]);
        line = log_wdata[0];
        for (k = 0; k < dmem_pkg::WORDS_PER_LINE; k++) begin
            check_word($sformatf("mem_wdata_o[%0d]", k),
                       shadow_word(victim + 32'(k * 4)), line[k*32 +: 32]);
        end
        check_word("mem_addr_o", a2, log_addr[1]);
        line = line_contents(victim[31:4]);
        check_word("memory word", merged, line[63:32]);

        // 4 indices by 4 tags, random byte enables
        for (n = 0; n < RANDOM_OPS; n++) begin
            rnd                = $random(seed);
            ra.flat            = '0;
            ra.fields.tag      = 22'(rnd[4:3]) + 22'h40;
            ra.fields.index    = {rnd[2:1], 4'h5};
            ra.fields.word     = rnd[6:5];
            if (rnd[0]) begin
                write_word(ra.flat, $random(seed), rnd[10:7]);
            end else begin
                read_and_check(ra.flat, edges);
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the data cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module wb_dcache_tb -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vwb_dcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- src.f
src/dcache_pkg.sv
src/dmem_pkg.sv
src/wb_dcache_datapath.sv
src/wb_dcache_controller.sv
src/wb_dcache_top.sv
bench/wb_dcache_assertions.sv
bench/wb_dcache_tb.sv

//--- src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int ADDR_WIDTH  = 32;
    localparam int DATA_WIDTH  = 32;

    localparam int IDX_BITS    = 6;
    localparam int OFFSET_BITS = 4;
    localparam int TAG_BITS    = ADDR_WIDTH - IDX_BITS - OFFSET_BITS;

    localparam int NO_OF_SETS  = 2 ** IDX_BITS;

    // Line offset splits into word within the line and byte within the word
    localparam int BYTE_BITS   = 2;
    localparam int WORD_BITS   = OFFSET_BITS - BYTE_BITS;

    typedef struct packed {
        logic [TAG_BITS-1:0]  tag;
        logic [IDX_BITS-1:0]  index;
        logic [WORD_BITS-1:0] word;
        logic [BYTE_BITS-1:0] byte_sel;
    } dcache_addr_fields_s;

    // Same address bits, seen flat or split into cache fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;
        dcache_addr_fields_s   fields;
    } dcache_addr_u;

    // One entry of the tag array
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic                valid;
        logic                dirty;
    } dcache_tag_s;

endpackage

`default_nettype wire

//--- src/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

    // One memory word carries a whole cache line
    localparam int LINE_WIDTH     = 128;

    // 32-bit LSU words held in one line
    localparam int WORDS_PER_LINE = 4;

endpackage

`default_nettype wire

//--- src/wb_dcache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module wb_dcache_controller (
    input  logic clk_i,
    input  logic rst_ni,

    // LSU handshake
    input  logic lsu_req_i,
    input  logic lsu_we_i,
    output logic lsu_ack_o,

    // Memory handshake
    input  logic mem_ack_i,
    output logic mem_req_o,
    output logic mem_we_o,

    // Datapath status and control
    input  logic cache_hit_i,
    input  logic cache_dirty_i,
    output logic cache_wr_o,
    output logic cache_line_wr_o,
    output logic writeback_sel_o,
    output logic rdata_en_o
);

    localparam logic [2:0] IDLE       = 3'd0;
    localparam logic [2:0] COMPARE    = 3'd1;
    localparam logic [2:0] WRITEBACK  = 3'd2;
    localparam logic [2:0] WB_RELEASE = 3'd3;
    localparam logic [2:0] REFILL     = 3'd4;
    localparam logic [2:0] ACK        = 3'd5;

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic       refill_done_q;
    logic       refill_done_d;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q       <= IDLE;
            refill_done_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            refill_done_q <= refill_done_d;
        end
    end

    always_comb begin
        state_d         = state_q;
        refill_done_d   = refill_done_q;
        cache_wr_o      = 1'b0;
        cache_line_wr_o = 1'b0;
        rdata_en_o      = 1'b0;

        case (state_q)
            IDLE: begin
                if (lsu_req_i) begin
                    state_d = COMPARE;
                end
            end
            COMPARE: begin
                if (cache_hit_i) begin
                    cache_wr_o = lsu_we_i;
                    rdata_en_o = !lsu_we_i;
                    state_d    = ACK;
                end else if (cache_dirty_i) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: begin
                if (mem_ack_i) begin
                    state_d = WB_RELEASE;
                end
            end
            WB_RELEASE: begin
                if (!mem_ack_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // Line is installed on the ack, then wait for ack to drop
                if (!refill_done_q) begin
                    if (mem_ack_i) begin
                        cache_line_wr_o = 1'b1;
                        refill_done_d   = 1'b1;
                    end
                end else if (!mem_ack_i) begin
                    refill_done_d = 1'b0;
                    state_d       = COMPARE;
                end
            end
            ACK: begin
                if (!lsu_req_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign lsu_ack_o       = (state_q == ACK);
    assign mem_req_o       = (state_q == WRITEBACK) || ((state_q == REFILL) && !refill_done_q);
    assign mem_we_o        = (state_q == WRITEBACK);
    assign writeback_sel_o = (state_q == WRITEBACK);

endmodule

`default_nettype wire

//--- src/wb_dcache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module wb_dcache_datapath (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // From the controller
    input  logic                                 cache_wr_i,
    input  logic                                 cache_line_wr_i,
    input  logic                                 writeback_sel_i,
    input  logic                                 rdata_en_i,

    // LSU side
    input  dcache_pkg::dcache_addr_u             lsu_addr_i,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]    lsu_wdata_i,
    input  logic [dcache_pkg::DATA_WIDTH/8-1:0]  lsu_be_i,

    // Memory side
    input  logic [dmem_pkg::LINE_WIDTH-1:0]      mem_rdata_i,

    output logic                                 cache_hit_o,
    output logic                                 cache_dirty_o,
    output logic [dcache_pkg::DATA_WIDTH-1:0]    lsu_rdata_o,
    output logic [dmem_pkg::LINE_WIDTH-1:0]      mem_wdata_o,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]    mem_addr_o
);

    dcache_pkg::dcache_tag_s tag_ram [dcache_pkg::NO_OF_SETS];
    logic [dmem_pkg::WORDS_PER_LINE-1:0][dcache_pkg::DATA_WIDTH-1:0]
        data_ram [dcache_pkg::NO_OF_SETS];

    logic [dcache_pkg::IDX_BITS-1:0]                                 idx;
    dcache_pkg::dcache_tag_s                                         tag_rd;
    logic [dmem_pkg::WORDS_PER_LINE-1:0][dcache_pkg::DATA_WIDTH-1:0] line_rd;
    logic [dmem_pkg::WORDS_PER_LINE-1:0][dcache_pkg::DATA_WIDTH-1:0] line_wr;
    logic [dcache_pkg::DATA_WIDTH-1:0]                               word_rd;
    logic [dcache_pkg::DATA_WIDTH-1:0]                               word_wr;
    logic [dcache_pkg::DATA_WIDTH-1:0]                               rdata_q;

    assign idx     = lsu_addr_i.fields.index;
    assign tag_rd  = tag_ram[idx];
    assign line_rd = data_ram[idx];
    assign word_rd = line_rd[lsu_addr_i.fields.word];

    // Byte lanes with their enable set take the LSU data
    always_comb begin
        word_wr = word_rd;
        for (int b = 0; b < dcache_pkg::DATA_WIDTH / 8; b++) begin
            if (lsu_be_i[b]) begin
                word_wr[b*8 +: 8] = lsu_wdata_i[b*8 +: 8];
            end
        end
    end

    always_comb begin
        line_wr = line_rd;
        line_wr[lsu_addr_i.fields.word] = word_wr;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < dcache_pkg::NO_OF_SETS; i++) begin
                tag_ram[i] <= '0;
            end
        end else if (cache_wr_i) begin
            tag_ram[idx].dirty <= 1'b1;
        end else if (cache_line_wr_i) begin
            // Freshly refilled line is clean
            tag_ram[idx].tag   <= lsu_addr_i.fields.tag;
            tag_ram[idx].valid <= 1'b1;
            tag_ram[idx].dirty <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cache_wr_i) begin
            data_ram[idx] <= line_wr;
        end else if (cache_line_wr_i) begin
            data_ram[idx] <= mem_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rdata_en_i) begin
            rdata_q <= word_rd;
        end
    end

    // Victim line goes back to the address built from its stored tag
    always_comb begin
        if (writeback_sel_i) begin
            mem_addr_o = {tag_rd.tag, idx, {dcache_pkg::OFFSET_BITS{1'b0}}};
        end else begin
            mem_addr_o = lsu_addr_i.flat;
        end
    end

    assign cache_hit_o   = tag_rd.valid && (tag_rd.tag == lsu_addr_i.fields.tag);
    assign cache_dirty_o = tag_rd.valid && tag_rd.dirty;
    assign mem_wdata_o   = line_rd;
    assign lsu_rdata_o   = rdata_q;

endmodule

`default_nettype wire

//--- src/wb_dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_dcache_top (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // LSU port
    input  logic                                 lsu_req_i,
    input  logic                                 lsu_we_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0]    lsu_addr_i,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]    lsu_wdata_i,
    input  logic [dcache_pkg::DATA_WIDTH/8-1:0]  lsu_be_i,
    output logic                                 lsu_ack_o,
    output logic [dcache_pkg::DATA_WIDTH-1:0]    lsu_rdata_o,

    // Line-wide memory port
    output logic                                 mem_req_o,
    output logic                                 mem_we_o,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]    mem_addr_o,
    output logic [dmem_pkg::LINE_WIDTH-1:0]      mem_wdata_o,
    input  logic                                 mem_ack_i,
    input  logic [dmem_pkg::LINE_WIDTH-1:0]      mem_rdata_i
);

    logic cache_wr;
    logic cache_line_wr;
    logic writeback_sel;
    logic rdata_en;
    logic cache_hit;
    logic cache_dirty;

    wb_dcache_controller u_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .lsu_req_i       (lsu_req_i),
        .lsu_we_i        (lsu_we_i),
        .lsu_ack_o       (lsu_ack_o),
        .mem_ack_i       (mem_ack_i),
        .mem_req_o       (mem_req_o),
        .mem_we_o        (mem_we_o),
        .cache_hit_i     (cache_hit),
        .cache_dirty_i   (cache_dirty),
        .cache_wr_o      (cache_wr),
        .cache_line_wr_o (cache_line_wr),
        .writeback_sel_o (writeback_sel),
        .rdata_en_o      (rdata_en)
    );

    wb_dcache_datapath u_dp (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .cache_wr_i      (cache_wr),
        .cache_line_wr_i (cache_line_wr),
        .writeback_sel_i (writeback_sel),
        .rdata_en_i      (rdata_en),
        .lsu_addr_i      (lsu_addr_i),
        .lsu_wdata_i     (lsu_wdata_i),
        .lsu_be_i        (lsu_be_i),
        .mem_rdata_i     (mem_rdata_i),
        .cache_hit_o     (cache_hit),
        .cache_dirty_o   (cache_dirty),
        .lsu_rdata_o     (lsu_rdata_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_addr_o      (mem_addr_o)
    );

endmodule

`default_nettype wire
